// ==== test/sha512_patterns.txt ====
# Record: flag I (INIT) or N (NEXT), 4 lines of 8 block words,
# then 2 lines of 8 expected digest words, or - when no check follows
I
61626380 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000018
ddaf35a1 93617aba cc417349 ae204131 12e6fa4e 89a97ea2 0a9eeee6 4b55d39a
2192992a 274fc1a8 36ba3c23 a3feebbd 454d4423 643ce80e 2a9ac94f a54ca49f
I
80000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
cf83e135 7eefb8bd f1542850 d66d8007 d620e405 0b5715dc 83f4a921 d36ce9ce
47d0d13c 5d85f2b0 ff8318d2 877eec2f 63b931bd 47417a81 a538327a f927da3e
I
61626364 65666768 62636465 66676869 63646566 6768696a 64656667 68696a6b
65666768 696a6b6c 66676869 6a6b6c6d 6768696a 6b6c6d6e 68696a6b 6c6d6e6f
696a6b6c 6d6e6f70 6a6b6c6d 6e6f7071 6b6c6d6e 6f707172 6c6d6e6f 70717273
6d6e6f70 71727374 6e6f7071 72737475 80000000 00000000 00000000 00000000
-
N
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000380
8e959b75 dae313da 8cf4f728 14fc143f 8f7779c6 eb9f7fa1 7299aead b6889018
501d289e 4900f7e4 331b99de c4b5433a c7d329ee b6dd2654 5e96e55b 874be909

// ==== verilog.f ====
+incdir+include
logic/sha512_pkg.sv
logic/sha512_step_if.sv
logic/sha512_ctrl.sv
logic/sha512_schedule.sv
logic/sha512_compress.sv
logic/sha512_regs.sv
logic/sha512_top.sv
test/sha512_tb.sv

// ==== Makefile ====
TOP := sha512_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== test/sha512_tb.sv ====
//----------------------------------------
// Testbench for the SHA-512 register engine
//----------------------------------------
`timescale 1ns/1ps

module sha512_tb;
  import sha512_pkg::*;

  logic                  clk;
  logic                  reset_n;
  logic                  cs;
  logic                  we;
  logic [addr_width-1:0] address;
  logic [data_width-1:0] write_data;
  logic [data_width-1:0] read_data;
  logic                  err;

  // Current record from the pattern file
  string       rec_flag;
  logic [31:0] rec_block [block_words];
  logic [31:0] rec_digest [digest_words];
  bit          rec_has_digest;
  // First record is kept for the busy test
  logic [31:0] abc_block [block_words];
  logic [31:0] abc_digest [digest_words];
  int          fd;
  int          num_records;

  sha512_top i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .err        (err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at the first failure");
  endtask

  // ----------------------------------------
  // Register port access
  // ----------------------------------------
  // Each access starts 1 ns after a rising edge and ends 1 ns after the next one
  task automatic write_reg(input logic [addr_width-1:0] addr, input logic [31:0] data,
                           input logic want_err);
    cs         = 1'b1;
    we         = 1'b1;
    address    = addr;
    write_data = data;
    @(negedge clk);
    assert (err == want_err) else begin
      $display("error %0t: write 0x%02h err %0b expected %0b", $time, addr, err, want_err);
      abort_run();
    end
    @(posedge clk);
    #1;
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic read_reg(input logic [addr_width-1:0] addr, output logic [31:0] data,
                          input logic want_err);
    cs         = 1'b1;
    we         = 1'b0;
    address    = addr;
    write_data = '0;
    @(negedge clk);
    data = read_data;
    assert (err == want_err) else begin
      $display("error %0t: read 0x%02h err %0b expected %0b", $time, addr, err, want_err);
      abort_run();
    end
    @(posedge clk);
    #1;
    cs = 1'b0;
  endtask

  task automatic expect_read(input logic [addr_width-1:0] addr, input logic [31:0] expected);
    logic [31:0] data;
    read_reg(addr, data, 1'b0);
    assert (data == expected) else begin
      $display("error %0t: read 0x%02h got %08h expected %08h", $time, addr, data, expected);
      abort_run();
    end
  endtask

  // Status bit 0 is ready, bit 1 is valid
  task automatic wait_status(input logic [31:0] want);
    logic [31:0] data;
    int          cycles;
    cycles = 0;
    read_reg(addr_status, data, 1'b0);
    while (data != want) begin
      cycles++;
      if (cycles > 200) begin
        $display("ready did not return with status %0h within 200 cycles", want);
        abort_run();
      end
      read_reg(addr_status, data, 1'b0);
    end
  endtask

  task automatic load_block(input logic [31:0] blk [block_words]);
    for (int i = 0; i < block_words; i++) begin
      write_reg(addr_block_base + 8'(i), blk[i], 1'b0);
    end
  endtask

  task automatic check_block(input logic [31:0] blk [block_words]);
    for (int i = 0; i < block_words; i++) begin
      expect_read(addr_block_base + 8'(i), blk[i]);
    end
  endtask

  task automatic check_digest(input logic [31:0] dig [digest_words]);
    for (int i = 0; i < digest_words; i++) begin
      expect_read(addr_digest_base + 8'(i), dig[i]);
    end
  endtask

  // ----------------------------------------
  // Pattern file
  // ----------------------------------------
  // Skips blank lines and lines that start with #
  task automatic next_line(output string line, output bit found);
    found = 1'b0;
    line  = "";
    while (!found) begin
      if ($fgets(line, fd) == 0) begin
        return;
      end
      found = line.len() > 0 && line[0] != 8'h23 && line[0] != 8'h0a;
    end
  endtask

  task automatic read_record(output bit found);
    string       line;
    logic [31:0] v [8];
    int          n;
    next_line(line, found);
    if (!found) begin
      return;
    end
    rec_flag = line.substr(0, 0);
    for (int k = 0; k < 6; k++) begin
      next_line(line, found);
      if (!found) begin
        $display("pattern file ends inside a record");
        abort_run();
      end
      // A dash in place of the digest means no check
      if (k == 4 && line.substr(0, 0) == "-") begin
        rec_has_digest = 1'b0;
        return;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                  v[7]);
      assert (n == 8) else begin
        $display("pattern line holds %0d words instead of 8", n);
        abort_run();
      end
      for (int j = 0; j < 8; j++) begin
        if (k < 4) begin
          rec_block[8*k+j] = v[j];
        end else begin
          rec_digest[8*(k-4)+j] = v[j];
        end
      end
    end
    rec_has_digest = 1'b1;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] data;
    bit          found;
    cs             = 1'b0;
    we             = 1'b0;
    address        = '0;
    write_data     = '0;
    reset_n        = 1'b0;
    num_records    = 0;
    rec_has_digest = 1'b0;
    void'($urandom(32'he7da_350f));
    fd = $fopen("test/sha512_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/sha512_patterns.txt");
      abort_run();
    end
    repeat (10) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(posedge clk);
    #1;

    // Idle after reset with ready set and no digest
    expect_read(addr_status, 32'h1);
    for (int i = 0; i < digest_words; i++) begin
      expect_read(addr_digest_base + 8'(i), '0);
    end

    read_record(found);
    while (found) begin
      assert (rec_flag == "I" || rec_flag == "N") else begin
        $display("pattern record has unknown command flag %s", rec_flag);
        abort_run();
      end
      load_block(rec_block);
      write_reg(addr_ctrl, (rec_flag == "I") ? 32'h1 : 32'h2, 1'b0);
      // An accepted command drops valid right away
      read_reg(addr_status, data, 1'b0);
      assert (data[status_valid_bit] == 1'b0) else begin
        $display("error %0t: valid still set after %s command", $time, rec_flag);
        abort_run();
      end
      wait_status(32'h3);
      if (rec_has_digest) begin
        check_digest(rec_digest);
        if (num_records == 0) begin
          abc_block  = rec_block;
          abc_digest = rec_digest;
        end
      end
      num_records++;
      read_record(found);
    end
    assert (num_records == 4) else begin
      $display("pattern file held %0d records instead of 4", num_records);
      abort_run();
    end

    // Bad accesses
    read_reg(8'h05, data, 1'b1);
    read_reg(8'h30, data, 1'b1);
    read_reg(8'hff, data, 1'b1);
    read_reg(addr_ctrl, data, 1'b1);
    write_reg(addr_digest_base, 32'hffff_ffff, 1'b1);
    write_reg(addr_digest_base + 8'd15, 32'h1234_5678, 1'b1);
    write_reg(addr_status, 32'h0, 1'b1);
    write_reg(8'h05, 32'hffff_ffff, 1'b1);
    expect_read(addr_status, 32'h3);
    check_digest(rec_digest);
    check_block(rec_block);

    // Writes and commands while busy are dropped
    load_block(abc_block);
    write_reg(addr_ctrl, 32'h1, 1'b0);
    // Valid drops at once, ready one cycle later
    expect_read(addr_status, 32'h1);
    expect_read(addr_status, 32'h0);
    for (int i = 0; i < block_words; i++) begin
      write_reg(addr_block_base + 8'(i), $urandom, 1'b0);
    end
    write_reg(addr_ctrl, 32'h1, 1'b0);
    check_block(abc_block);
    wait_status(32'h3);
    check_digest(abc_digest);
    check_block(abc_block);

    // Zeroize clears block, digest and valid
    write_reg(addr_ctrl, 32'h4, 1'b0);
    wait_status(32'h1);
    for (int i = 0; i < block_words; i++) begin
      expect_read(addr_block_base + 8'(i), '0);
    end
    for (int i = 0; i < digest_words; i++) begin
      expect_read(addr_digest_base + 8'(i), '0);
    end

    $fclose(fd);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== logic/sha512_top.sv ====
//----------------------------------------
// SHA-512 engine top level
//----------------------------------------
`timescale 1ns/1ps

module sha512_top (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              cs,
  input  logic                              we,
  input  logic [sha512_pkg::addr_width-1:0] address,
  input  logic [sha512_pkg::data_width-1:0] write_data,
  output logic [sha512_pkg::data_width-1:0] read_data,
  output logic                              err
);
  import sha512_pkg::*;

  logic    init_cmd;
  logic    next_cmd;
  logic    zeroize;
  logic    ready;
  logic    digest_done;
  block_t  block;
  word_t   w;
  digest_t digest;

  sha512_step_if step ();

  sha512_regs i_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .cs          (cs),
    .we          (we),
    .address     (address),
    .write_data  (write_data),
    .read_data   (read_data),
    .err         (err),
    .ready       (ready),
    .digest_done (digest_done),
    .digest      (digest),
    .init_cmd    (init_cmd),
    .next_cmd    (next_cmd),
    .zeroize     (zeroize),
    .block       (block)
  );

  sha512_ctrl i_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .init_cmd    (init_cmd),
    .next_cmd    (next_cmd),
    .zeroize     (zeroize),
    .ready       (ready),
    .digest_done (digest_done),
    .step        (step.ctrl)
  );

  sha512_schedule i_schedule (
    .clk     (clk),
    .reset_n (reset_n),
    .block   (block),
    .w       (w),
    .step    (step.sched)
  );

  sha512_compress i_compress (
    .clk     (clk),
    .reset_n (reset_n),
    .w       (w),
    .digest  (digest),
    .step    (step.comp)
  );

endmodule

// ==== logic/sha512_regs.sv ====
//----------------------------------------
// SHA-512 register port, block storage,
// command pulses, status and digest readback
//----------------------------------------
`timescale 1ns/1ps

module sha512_regs (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                cs,
  input  logic                                we,
  input  logic [sha512_pkg::addr_width-1:0]   address,
  input  logic [sha512_pkg::data_width-1:0]   write_data,
  output logic [sha512_pkg::data_width-1:0]   read_data,
  output logic                                err,
  input  logic                                ready,
  input  logic                                digest_done,
  input  sha512_pkg::digest_t                 digest,
  output logic                                init_cmd,
  output logic                                next_cmd,
  output logic                                zeroize,
  output sha512_pkg::block_t                  block
);
  import sha512_pkg::*;

  logic [data_width-1:0] block_q [block_words];
  logic                  valid_q;

  logic                  is_ctrl;
  logic                  is_status;
  logic                  is_block;
  logic                  is_digest;
  logic [addr_width-1:0] block_off;
  logic [addr_width-1:0] digest_off;
  logic [block_aw-1:0]   block_idx;
  logic [digest_aw-1:0]  digest_idx;
  logic                  ctrl_wr;
  logic                  cmd_ok;
  logic [data_width-1:0] status_word;
  logic [data_width-1:0] digest_word;

  // ----------------------------------------
  // Address decode
  // ----------------------------------------
  // Offsets wrap below the base so one compare covers the range
  assign block_off  = address - addr_block_base;
  assign digest_off = address - addr_digest_base;
  assign is_ctrl    = (address == addr_ctrl);
  assign is_status  = (address == addr_status);
  assign is_block   = (block_off < addr_width'(block_words));
  assign is_digest  = (digest_off < addr_width'(digest_words));
  assign block_idx  = block_off[block_aw-1:0];
  assign digest_idx = digest_off[digest_aw-1:0];

  assign ctrl_wr = cs && we && is_ctrl;
  // INIT and NEXT only count while the engine is idle
  assign cmd_ok  = ctrl_wr && ready &&
                   (write_data[ctrl_init_bit] || write_data[ctrl_next_bit]);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init_cmd <= 1'b0;
      next_cmd <= 1'b0;
      zeroize  <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      init_cmd <= cmd_ok && write_data[ctrl_init_bit];
      next_cmd <= cmd_ok && !write_data[ctrl_init_bit];
      zeroize  <= ctrl_wr && write_data[ctrl_zeroize_bit];
      if (zeroize || cmd_ok) begin
        valid_q <= 1'b0;
      end else if (digest_done) begin
        valid_q <= 1'b1;
      end
    end
  end

  // Message block words
  always_ff @(posedge clk) begin
    if (zeroize) begin
      for (int i = 0; i < block_words; i++) begin
        block_q[i] <= '0;
      end
    end else if (cs && we && is_block && ready) begin
      block_q[block_idx] <= write_data;
    end
  end

  // Pairs of port words form one 64-bit block word, big-endian
  always_comb begin
    for (int i = 0; i < block_words / 2; i++) begin
      block[i] = {block_q[2*i], block_q[2*i+1]};
    end
  end

  // ----------------------------------------
  // Readback and error flag
  // ----------------------------------------
  always_comb begin
    status_word                   = '0;
    status_word[status_ready_bit] = ready;
    status_word[status_valid_bit] = valid_q;
  end

  assign digest_word = digest_idx[0] ? digest[digest_idx[digest_aw-1:1]][31:0]
                                     : digest[digest_idx[digest_aw-1:1]][63:32];

  always_comb begin
    read_data = '0;
    if (cs) begin
      if (is_status) begin
        read_data = status_word;
      end else if (is_block) begin
        read_data = block_q[block_idx];
      end else if (is_digest) begin
        read_data = digest_word;
      end
    end
  end

  // Writes go to control or block, reads to status, block or digest
  assign err = cs && (we ? !(is_ctrl || is_block)
                         : !(is_status || is_block || is_digest));

endmodule

// ==== logic/sha512_compress.sv ====
//----------------------------------------
// SHA-512 round datapath and chained state
//----------------------------------------
`timescale 1ns/1ps

module sha512_compress (
  input  logic                clk,
  input  logic                reset_n,
  input  sha512_pkg::word_t   w,
  output sha512_pkg::digest_t digest,
  sha512_step_if.comp         step
);
  import sha512_pkg::*;

  // Chained hash state H0..H7
  digest_t h_q;
  // Working variables a..h at index 0..7
  digest_t work_q;

  word_t a;
  word_t b;
  word_t c;
  word_t d;
  word_t e;
  word_t f;
  word_t g;
  word_t h;
  word_t t1;
  word_t t2;

  assign a = work_q[0];
  assign b = work_q[1];
  assign c = work_q[2];
  assign d = work_q[3];
  assign e = work_q[4];
  assign f = work_q[5];
  assign g = work_q[6];
  assign h = work_q[7];

  // ----------------------------------------
  // Round function
  // ----------------------------------------
  assign t1 = h + big_sigma1(e) + ch(e, f, g) + sha512_k[step.round_idx] + w;
  assign t2 = big_sigma0(a) + maj(a, b, c);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      h_q    <= '0;
      work_q <= '0;
    end else if (step.clear) begin
      h_q    <= '0;
      work_q <= '0;
    end else begin
      if (step.init) begin
        h_q <= sha512_iv;
      end
      // On INIT the working set starts from the IV directly
      if (step.load) begin
        work_q <= step.init ? sha512_iv : h_q;
      end
      if (step.round) begin
        work_q <= {t1 + t2, a, b, c, d + t1, e, f, g};
      end
      if (step.finish) begin
        for (int i = 0; i < 8; i++) begin
          h_q[i] <= h_q[i] + work_q[i];
        end
      end
    end
  end

  assign digest = h_q;

endmodule

// ==== logic/sha512_schedule.sv ====
//----------------------------------------
// SHA-512 message schedule, one W per round
//----------------------------------------
`timescale 1ns/1ps

module sha512_schedule (
  input  logic               clk,
  input  logic               reset_n,
  input  sha512_pkg::block_t block,
  output sha512_pkg::word_t  w,
  sha512_step_if.sched       step
);
  import sha512_pkg::*;

  // Sliding window of 16 words with W[t] at index 0
  block_t w_q;
  word_t  w_new;

  // W[t+16] from W[t+14], W[t+9], W[t+1] and W[t]
  assign w_new = small_sigma1(w_q[14]) + w_q[9] + small_sigma0(w_q[1]) + w_q[0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      w_q <= '0;
    end else if (step.clear) begin
      w_q <= '0;
    end else if (step.load) begin
      w_q <= block;
    end else if (step.round) begin
      w_q <= {w_q[1:15], w_new};
    end
  end

  // Rounds 0-15 see the block words in order
  assign w = w_q[0];

endmodule

// ==== logic/sha512_ctrl.sv ====
//----------------------------------------
// SHA-512 block sequencer FSM
//----------------------------------------
`timescale 1ns/1ps

module sha512_ctrl (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        init_cmd,
  input  logic        next_cmd,
  input  logic        zeroize,
  output logic        ready,
  output logic        digest_done,
  sha512_step_if.ctrl step
);
  import sha512_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_rounds,
    st_finish
  } state_t;

  state_t     state_q;
  state_t     state_d;
  round_idx_t round_q;
  logic       use_iv_q;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (init_cmd || next_cmd) begin
          state_d = st_load;
        end
      end
      st_load:   state_d = st_rounds;
      st_rounds: begin
        if (round_q == round_idx_t'(num_rounds - 1)) begin
          state_d = st_finish;
        end
      end
      st_finish: state_d = st_idle;
      default:   state_d = st_idle;
    endcase
    // Zeroize aborts any block in flight
    if (zeroize) begin
      state_d = st_idle;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= st_idle;
      round_q  <= '0;
      use_iv_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (zeroize) begin
        use_iv_q <= 1'b0;
      end else if (state_q == st_idle && (init_cmd || next_cmd)) begin
        use_iv_q <= init_cmd;
      end
      // Counter walks 0..79 during the round phase only
      if (state_q == st_rounds && !zeroize) begin
        round_q <= round_q + 1'b1;
      end else begin
        round_q <= '0;
      end
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign ready       = (state_q == st_idle);
  assign digest_done = (state_q == st_finish);

  assign step.init      = (state_q == st_load) && use_iv_q;
  assign step.load      = (state_q == st_load);
  assign step.round     = (state_q == st_rounds);
  assign step.round_idx = round_q;
  assign step.finish    = (state_q == st_finish);
  assign step.clear     = zeroize;

endmodule

// ==== logic/sha512_step_if.sv ====
//----------------------------------------
// Step controls from sequencer to datapath
//----------------------------------------
`timescale 1ns/1ps

interface sha512_step_if;
  import sha512_pkg::*;

  // Load hash state with the initial value
  logic       init;
  // Copy block into schedule and state into a-h
  logic       load;
  // High for each of the 80 round cycles
  logic       round;
  round_idx_t round_idx;
  // Add a-h into the hash state
  logic       finish;
  // Zeroize all datapath state
  logic       clear;

  modport ctrl (
    output init, load, round, round_idx, finish, clear
  );

  modport sched (
    input load, round, clear
  );

  modport comp (
    input init, load, round, round_idx, finish, clear
  );

endinterface

// ==== logic/sha512_pkg.sv ====
//----------------------------------------
// SHA-512 sizes, types, register map,
// initial hash value and round functions
//----------------------------------------
package sha512_pkg;

  localparam int data_width   = 32;
  localparam int addr_width   = 8;
  localparam int block_words  = 32;
  localparam int digest_words = 16;
  localparam int block_aw     = $clog2(block_words);
  localparam int digest_aw    = $clog2(digest_words);
  localparam int num_rounds   = 80;

  typedef logic [63:0] word_t;
  // Index 0 is the most significant word
  typedef word_t [0:15] block_t;
  typedef word_t [0:7]  digest_t;
  typedef logic [6:0]   round_idx_t;

  // Register map in word addresses
  localparam logic [addr_width-1:0] addr_ctrl        = 8'h00;
  localparam logic [addr_width-1:0] addr_status      = 8'h01;
  localparam logic [addr_width-1:0] addr_block_base  = 8'h10;
  localparam logic [addr_width-1:0] addr_digest_base = 8'h40;

  localparam int ctrl_init_bit    = 0;
  localparam int ctrl_next_bit    = 1;
  localparam int ctrl_zeroize_bit = 2;
  localparam int status_ready_bit = 0;
  localparam int status_valid_bit = 1;

  localparam digest_t sha512_iv = {
    64'h6a09e667f3bcc908, 64'hbb67ae8584caa73b, 64'h3c6ef372fe94f82b, 64'ha54ff53a5f1d36f1,
    64'h510e527fade682d1, 64'h9b05688c2b3e6c1f, 64'h1f83d9abfb41bd6b, 64'h5be0cd19137e2179
  };

  `include "sha512_k.svh"

  function automatic word_t rotr(word_t x, int unsigned n);
    return (x >> n) | (x << (64 - n));
  endfunction

  // Message schedule functions
  function automatic word_t small_sigma0(word_t x);
    return rotr(x, 1) ^ rotr(x, 8) ^ (x >> 7);
  endfunction

  function automatic word_t small_sigma1(word_t x);
    return rotr(x, 19) ^ rotr(x, 61) ^ (x >> 6);
  endfunction

  // Round functions
  function automatic word_t big_sigma0(word_t x);
    return rotr(x, 28) ^ rotr(x, 34) ^ rotr(x, 39);
  endfunction

  function automatic word_t big_sigma1(word_t x);
    return rotr(x, 14) ^ rotr(x, 18) ^ rotr(x, 41);
  endfunction

  function automatic word_t ch(word_t x, word_t y, word_t z);
    return (x & y) ^ (~x & z);
  endfunction

  function automatic word_t maj(word_t x, word_t y, word_t z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

endpackage

// ==== include/sha512_k.svh ====
//----------------------------------------
// SHA-512 round constant table K[0..79]
//----------------------------------------
`ifndef SHA512_K_SVH
`define SHA512_K_SVH

// First 64 bits of the fractional parts of the cube roots of the first 80 primes
localparam word_t sha512_k [0:79] = '{
  64'h428a2f98d728ae22,
  64'h7137449123ef65cd,
  64'hb5c0fbcfec4d3b2f,
  64'he9b5dba58189dbbc,
  64'h3956c25bf348b538,
  64'h59f111f1b605d019,
  64'h923f82a4af194f9b,
  64'hab1c5ed5da6d8118,
  64'hd807aa98a3030242,
  64'h12835b0145706fbe,
  64'h243185be4ee4b28c,
  64'h550c7dc3d5ffb4e2,
  64'h72be5d74f27b896f,
  64'h80deb1fe3b1696b1,
  64'h9bdc06a725c71235,
  64'hc19bf174cf692694,
  64'he49b69c19ef14ad2,
  64'hefbe4786384f25e3,
  64'h0fc19dc68b8cd5b5,
  64'h240ca1cc77ac9c65,
  64'h2de92c6f592b0275,
  64'h4a7484aa6ea6e483,
  64'h5cb0a9dcbd41fbd4,
  64'h76f988da831153b5,
  64'h983e5152ee66dfab,
  64'ha831c66d2db43210,
  64'hb00327c898fb213f,
  64'hbf597fc7beef0ee4,
  64'hc6e00bf33da88fc2,
  64'hd5a79147930aa725,
  64'h06ca6351e003826f,
  64'h142929670a0e6e70,
  64'h27b70a8546d22ffc,
  64'h2e1b21385c26c926,
  64'h4d2c6dfc5ac42aed,
  64'h53380d139d95b3df,
  64'h650a73548baf63de,
  64'h766a0abb3c77b2a8,
  64'h81c2c92e47edaee6,
  64'h92722c851482353b,
  64'ha2bfe8a14cf10364,
  64'ha81a664bbc423001,
  64'hc24b8b70d0f89791,
  64'hc76c51a30654be30,
  64'hd192e819d6ef5218,
  64'hd69906245565a910,
  64'hf40e35855771202a,
  64'h106aa07032bbd1b8,
  64'h19a4c116b8d2d0c8,
  64'h1e376c085141ab53,
  64'h2748774cdf8eeb99,
  64'h34b0bcb5e19b48a8,
  64'h391c0cb3c5c95a63,
  64'h4ed8aa4ae3418acb,
  64'h5b9cca4f7763e373,
  64'h682e6ff3d6b2b8a3,
  64'h748f82ee5defb2fc,
  64'h78a5636f43172f60,
  64'h84c87814a1f0ab72,
  64'h8cc702081a6439ec,
  64'h90befffa23631e28,
  64'ha4506cebde82bde9,
  64'hbef9a3f7b2c67915,
  64'hc67178f2e372532b,
  64'hca273eceea26619c,
  64'hd186b8c721c0c207,
  64'heada7dd6cde0eb1e,
  64'hf57d4f7fee6ed178,
  64'h06f067aa72176fba,
  64'h0a637dc5a2c898a6,
  64'h113f9804bef90dae,
  64'h1b710b35131c471b,
  64'h28db77f523047d84,
  64'h32caab7b40c72493,
  64'h3c9ebe0a15c9bebc,
  64'h431d67c49c100d4c,
  64'h4cc5d4becb3e42b6,
  64'h597f299cfc657e2a,
  64'h5fcb6fab3ad6faec,
  64'h6c44198c4a475817
};

`endif
